// File: compile.f
video_pkg.sv
render_if.sv
video_vga.sv
line_renderer.sv
line_buffer.sv
palette_ram.sv
video_top.sv
tb_clock.sv
tb_video_top.sv

// File: Makefile
SRCS = video_pkg.sv render_if.sv video_vga.sv line_renderer.sv line_buffer.sv \
       palette_ram.sv video_top.sv tb_clock.sv tb_video_top.sv

.PHONY: all run clean

all: obj_dir/Vtb_video_top

obj_dir/Vtb_video_top: compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_video_top -f compile.f

run: obj_dir/Vtb_video_top
	./obj_dir/Vtb_video_top | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_video_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_video_top;
    import video_pkg::*;

    localparam int N_ROWS     = 3;
    localparam int N_PAL      = 2;
    localparam int N_PROBE    = 10;
    localparam int WAIT_LIMIT = 500000;

    logic       clk;
    logic       rst;
    logic       pal_wr;
    pal_idx_t   pal_addr;
    rgb_t       pal_data;
    pal_idx_t   bg_color;
    pal_idx_t   rect_color;
    coord_t     rect_x0;
    coord_t     rect_x1;
    coord_t     rect_y0;
    coord_t     rect_y1;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic       vga_hsync;
    logic       vga_vsync;

    rgb_t       pal_model [0:255];
    int         errors;
    int         probes_checked;
    int         probe_hits;
    int         cur_row;
    logic       check_en;
    coord_t     disp_x;
    coord_t     disp_y;
    logic       x_locked;
    logic       y_locked;
    logic       hs_prev;
    logic       vs_prev;

    tb_clock u_clock (.clk(clk));

    video_top UUT (
        .clk        (clk),
        .rst        (rst),
        .pal_wr     (pal_wr),
        .pal_addr   (pal_addr),
        .pal_data   (pal_data),
        .bg_color   (bg_color),
        .rect_color (rect_color),
        .rect_x0    (rect_x0),
        .rect_x1    (rect_x1),
        .rect_y0    (rect_y0),
        .rect_y1    (rect_y1),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync)
    );

    // ======================================================================
    // Scenario table
    // ======================================================================

    // Row 1 rewrites index 2 and row 2 rewrites both indices it uses
    pal_idx_t    tbl_pal_idx [0:N_ROWS-1][0:N_PAL-1] = '{
        '{8'd1, 8'd2}, '{8'd2, 8'd3}, '{8'd3, 8'd2}};
    logic [11:0] tbl_pal_rgb [0:N_ROWS-1][0:N_PAL-1] = '{
        '{12'hF00, 12'h0F0}, '{12'h00F, 12'h777}, '{12'hABC, 12'h5A5}};
    pal_idx_t    tbl_bg   [0:N_ROWS-1] = '{8'd1, 8'd3, 8'd2};
    pal_idx_t    tbl_rect [0:N_ROWS-1] = '{8'd2, 8'd2, 8'd3};
    coord_t      tbl_x0   [0:N_ROWS-1] = '{10'd100, 10'd10,  10'd600};
    coord_t      tbl_x1   [0:N_ROWS-1] = '{10'd199, 10'd20,  10'd639};
    coord_t      tbl_y0   [0:N_ROWS-1] = '{10'd50,  10'd0,   10'd479};
    coord_t      tbl_y1   [0:N_ROWS-1] = '{10'd149, 10'd479, 10'd479};

    // Probe points, corners and just outside each bound, plus lines 0 and 479
    coord_t tbl_px [0:N_ROWS-1][0:N_PROBE-1] = '{
        '{10'd100, 10'd199, 10'd150, 10'd99, 10'd200,
          10'd150, 10'd150, 10'd0,   10'd639, 10'd320},
        '{10'd10,  10'd20,  10'd15,  10'd9,  10'd21,
          10'd9,   10'd21,  10'd639, 10'd0,   10'd320},
        '{10'd600, 10'd639, 10'd599, 10'd620, 10'd620,
          10'd0,   10'd639, 10'd300, 10'd0,   10'd100}};
    coord_t tbl_py [0:N_ROWS-1][0:N_PROBE-1] = '{
        '{10'd50,  10'd149, 10'd100, 10'd100, 10'd100,
          10'd49,  10'd150, 10'd0,   10'd479, 10'd240},
        '{10'd0,   10'd479, 10'd240, 10'd0,   10'd0,
          10'd479, 10'd479, 10'd0,   10'd479, 10'd100},
        '{10'd479, 10'd479, 10'd479, 10'd478, 10'd0,
          10'd0,   10'd0,   10'd300, 10'd479, 10'd200}};

    // ======================================================================
    // Reference model and compare tasks
    // ======================================================================

    function automatic rgb_t expected_pixel(input coord_t x, input coord_t y);
        if (x >= H_ACTIVE || y >= V_ACTIVE) begin
            return '0;
        end
        if (x >= rect_x0 && x <= rect_x1 && y >= rect_y0 && y <= rect_y1) begin
            return pal_model[rect_color];
        end
        return pal_model[bg_color];
    endfunction

    task automatic check_rgb(input rgb_t actual, input rgb_t expected, input string name);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_position();
        rgb_t act;
        logic exp_hs;
        logic exp_vs;
        act.r  = vga_r;
        act.g  = vga_g;
        act.b  = vga_b;
        exp_hs = (disp_x >= H_ACTIVE + H_FRONT_PORCH) &&
                 (disp_x <  H_ACTIVE + H_FRONT_PORCH + H_SYNC);
        exp_vs = (disp_y >= V_ACTIVE + V_FRONT_PORCH) &&
                 (disp_y <  V_ACTIVE + V_FRONT_PORCH + V_SYNC);
        check_bit(vga_hsync, exp_hs, "vga_hsync");
        check_bit(vga_vsync, exp_vs, "vga_vsync");
        if (disp_x >= H_ACTIVE || disp_y >= V_ACTIVE) begin
            check_rgb(act, '0, "vga_rgb in blanking");
        end
        for (int p = 0; p < N_PROBE; p++) begin
            if (tbl_px[cur_row][p] == disp_x && tbl_py[cur_row][p] == disp_y) begin
                probe_hits++;
                check_rgb(act, expected_pixel(disp_x, disp_y),
                          $sformatf("vga_rgb at (%0d,%0d)", disp_x, disp_y));
            end
        end
    endtask

    // ======================================================================
    // Displayed position, locked once to the first sync edges
    // ======================================================================

    always @(negedge clk) begin
        if (rst) begin
            disp_x   = '0;
            disp_y   = '0;
            x_locked = 1'b0;
            y_locked = 1'b0;
            hs_prev  = 1'b0;
            vs_prev  = 1'b0;
        end else begin
            if (disp_x == H_TOTAL - 10'd1) begin
                disp_x = '0;
                disp_y = (disp_y == V_TOTAL - 10'd1) ? '0 : disp_y + 10'd1;
            end else begin
                disp_x = disp_x + 10'd1;
            end
            if (!x_locked && vga_hsync && !hs_prev) begin
                disp_x   = H_ACTIVE + H_FRONT_PORCH;
                x_locked = 1'b1;
            end
            if (!y_locked && !vga_vsync && vs_prev) begin
                disp_y   = V_ACTIVE + V_FRONT_PORCH + V_SYNC;
                y_locked = 1'b1;
            end
            hs_prev = vga_hsync;
            vs_prev = vga_vsync;
            if (check_en) begin
                check_position();
            end
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================

    task automatic write_palette(input pal_idx_t idx, input rgb_t color);
        @(posedge clk);
        #1;
        pal_wr         = 1'b1;
        pal_addr       = idx;
        pal_data       = color;
        pal_model[idx] = color;
        @(posedge clk);
        #1;
        pal_wr = 1'b0;
    endtask

    task automatic wait_vsync_fall(output logic ok);
        int   n;
        logic prev;
        ok   = 1'b0;
        n    = 0;
        prev = vga_vsync;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (prev && !vga_vsync) begin
                ok = 1'b1;
            end
            prev = vga_vsync;
            n++;
        end
        if (!ok) begin
            $display("Timeout: no falling edge of vga_vsync within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic apply_row(input int r, output logic ok);
        cur_row = r;
        for (int p = 0; p < N_PAL; p++) begin
            write_palette(tbl_pal_idx[r][p], rgb_t'(tbl_pal_rgb[r][p]));
        end
        @(posedge clk);
        #1;
        bg_color   = tbl_bg[r];
        rect_color = tbl_rect[r];
        rect_x0    = tbl_x0[r];
        rect_x1    = tbl_x1[r];
        rect_y0    = tbl_y0[r];
        rect_y1    = tbl_y1[r];
        // The frame after this edge is rendered entirely with the new settings
        wait_vsync_fall(ok);
        if (ok) begin
            probe_hits = 0;
            @(posedge clk);
            #1;
            check_en = 1'b1;
            wait_vsync_fall(ok);
            @(posedge clk);
            #1;
            check_en = 1'b0;
            if (ok && probe_hits != N_PROBE) begin
                errors++;
                $display("Row %0d reached only %0d of %0d probe points", r, probe_hits, N_PROBE);
            end
            probes_checked += probe_hits;
        end
    endtask

    initial begin
        logic run_ok;
        int   rows_done;
        rst            = 1'b1;
        pal_wr         = 1'b0;
        pal_addr       = '0;
        pal_data       = '0;
        bg_color       = '0;
        rect_color     = '0;
        rect_x0        = '0;
        rect_x1        = '0;
        rect_y0        = '0;
        rect_y1        = '0;
        check_en       = 1'b0;
        cur_row        = 0;
        errors         = 0;
        probes_checked = 0;
        probe_hits     = 0;
        rows_done      = 0;
        run_ok         = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int r = 0; r < N_ROWS && run_ok; r++) begin
            apply_row(r, run_ok);
            rows_done++;
        end

        $display("Done: %0d of %0d rows, %0d probe points, %0d errors",
                 rows_done, N_ROWS, probes_checked, errors);
        if (run_ok && errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 4 ns period, starting low
    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

`default_nettype wire

// File: video_top.sv
`timescale 1ns/10ps
`default_nettype none

module video_top (
    input  logic                clk,
    input  logic                rst,

    // Palette host port
    input  logic                pal_wr,
    input  video_pkg::pal_idx_t pal_addr,
    input  video_pkg::rgb_t     pal_data,

    // Drawing registers
    input  video_pkg::pal_idx_t bg_color,
    input  video_pkg::pal_idx_t rect_color,
    input  video_pkg::coord_t   rect_x0,
    input  video_pkg::coord_t   rect_x1,
    input  video_pkg::coord_t   rect_y0,
    input  video_pkg::coord_t   rect_y1,

    // VGA pins
    output logic [3:0]          vga_r,
    output logic [3:0]          vga_g,
    output logic [3:0]          vga_b,
    output logic                vga_hsync,
    output logic                vga_vsync
);
    import video_pkg::*;

    coord_t   linebuf_idx;
    pal_idx_t pix_idx;
    rgb_t     rgb_data;
    logic     start_of_line;
    logic     start_of_screen;

    render_if rif (.clk(clk));

    video_vga u_vga (
        .clk             (clk),
        .rst             (rst),
        .linebuf_idx     (linebuf_idx),
        .rgb_data        (rgb_data),
        .start_of_screen (start_of_screen),
        .start_of_line   (start_of_line),
        .vga_r           (vga_r),
        .vga_g           (vga_g),
        .vga_b           (vga_b),
        .vga_hsync       (vga_hsync),
        .vga_vsync       (vga_vsync)
    );

    line_renderer u_renderer (
        .clk             (clk),
        .rst             (rst),
        .start_of_line   (start_of_line),
        .start_of_screen (start_of_screen),
        .bg_color        (bg_color),
        .rect_color      (rect_color),
        .rect_x0         (rect_x0),
        .rect_x1         (rect_x1),
        .rect_y0         (rect_y0),
        .rect_y1         (rect_y1),
        .wr              (rif.renderer)
    );

    line_buffer u_linebuf (
        .clk           (clk),
        .rst           (rst),
        .start_of_line (start_of_line),
        .wr            (rif.buffer),
        .rd_idx        (linebuf_idx),
        .pix_idx       (pix_idx)
    );

    palette_ram u_palette (
        .clk   (clk),
        .rst   (rst),
        .wr    (pal_wr),
        .waddr (pal_addr),
        .wdata (pal_data),
        .raddr (pix_idx),
        .rdata (rgb_data)
    );

endmodule

`default_nettype wire

// File: palette_ram.sv
`timescale 1ns/10ps
`default_nettype none

module palette_ram (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr,
    input  video_pkg::pal_idx_t waddr,
    input  video_pkg::rgb_t     wdata,
    input  video_pkg::pal_idx_t raddr,
    output video_pkg::rgb_t     rdata
);
    import video_pkg::*;

    rgb_t table_q [0:255];

    // Host side, one entry per strobe
    always_ff @(posedge clk) begin
        if (wr) begin
            table_q[waddr] <= wdata;
        end
    end

    // A write is seen by a read issued in the following cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            rdata <= table_q[raddr];
        end
    end

endmodule

`default_nettype wire

// File: line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module line_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_of_line,
    render_if.buffer            wr,
    input  video_pkg::coord_t   rd_idx,
    output video_pkg::pal_idx_t pix_idx
);
    import video_pkg::*;

    // Bank 0 and bank 1, one of them shown while the other is filled
    pal_idx_t mem [0:1][0:H_ACTIVE-1];

    logic     front_bank;
    logic     back_bank;

    assign back_bank = ~front_bank;

    // ======================================================================
    // Bank select
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            front_bank <= 1'b0;
        end else if (start_of_line) begin
            front_bank <= ~front_bank;
        end
    end

    // ======================================================================
    // Write and read ports
    // ======================================================================

    always_ff @(posedge wr.clk) begin
        if (wr.wr_en) begin
            mem[back_bank][wr.wr_idx] <= wr.wr_color;
        end
    end

    // Reads past the active width happen in blanking, where the value is unused
    always_ff @(posedge clk) begin
        if (rd_idx < H_ACTIVE) begin
            pix_idx <= mem[front_bank][rd_idx];
        end
    end

    a_wr_in_range: assert property (
        @(posedge clk) disable iff (rst) wr.wr_en |-> (wr.wr_idx < H_ACTIVE)
    ) else $error("line buffer write index %0d out of range", wr.wr_idx);

endmodule

`default_nettype wire

// File: line_renderer.sv
`timescale 1ns/10ps
`default_nettype none

module line_renderer (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_of_line,
    input  logic                start_of_screen,
    input  video_pkg::pal_idx_t bg_color,
    input  video_pkg::pal_idx_t rect_color,
    input  video_pkg::coord_t   rect_x0,
    input  video_pkg::coord_t   rect_x1,
    input  video_pkg::coord_t   rect_y0,
    input  video_pkg::coord_t   rect_y1,
    render_if.renderer          wr
);
    import video_pkg::*;

    render_state_t state;
    coord_t        x_q;
    coord_t        line_q;
    logic          start_fill;
    logic          in_rect;

    // Drawing registers as sampled for the line being filled
    pal_idx_t      bg_q;
    pal_idx_t      rect_q;
    coord_t        x0_q;
    coord_t        x1_q;
    coord_t        y0_q;
    coord_t        y1_q;

    assign start_fill = (state == RS_IDLE) && start_of_line;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= RS_IDLE;
            x_q    <= '0;
            line_q <= '0;
        end else begin
            case (state)
                RS_IDLE: begin
                    if (start_fill) begin
                        state  <= RS_FILL;
                        x_q    <= '0;
                        // Frame strobe means the next line shown is line 0
                        line_q <= start_of_screen ? '0 : line_q + 10'd1;
                    end
                end
                RS_FILL: begin
                    x_q <= x_q + 10'd1;
                    if (x_q == H_ACTIVE - 10'd1) begin
                        state <= RS_IDLE;
                    end
                end
                default: state <= RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_fill) begin
            bg_q   <= bg_color;
            rect_q <= rect_color;
            x0_q   <= rect_x0;
            x1_q   <= rect_x1;
            y0_q   <= rect_y0;
            y1_q   <= rect_y1;
        end
    end

    // Bounds are inclusive on all four sides
    assign in_rect = (x_q >= x0_q) && (x_q <= x1_q) &&
                     (line_q >= y0_q) && (line_q <= y1_q);

    assign wr.wr_en    = (state == RS_FILL);
    assign wr.wr_idx   = x_q;
    assign wr.wr_color = in_rect ? rect_q : bg_q;

    // A fill must be done before the buffer swaps banks again
    a_fill_done: assert property (
        @(posedge clk) disable iff (rst) (state == RS_FILL) |-> !start_of_line
    ) else $error("start_of_line while a fill is still running");

endmodule

`default_nettype wire

// File: video_vga.sv
`timescale 1ns/10ps
`default_nettype none

module video_vga (
    input  logic              clk,
    input  logic              rst,

    output video_pkg::coord_t linebuf_idx,
    input  video_pkg::rgb_t   rgb_data,

    output logic              start_of_screen,
    output logic              start_of_line,

    output logic [3:0]        vga_r,
    output logic [3:0]        vga_g,
    output logic [3:0]        vga_b,
    output logic              vga_hsync,
    output logic              vga_vsync
);
    import video_pkg::*;

    coord_t     x_cnt;
    coord_t     y_cnt;
    logic       h_last;
    logic       v_last;
    logic       v_last2;
    logic       hsync;
    logic       vsync;
    logic       active;
    logic [1:0] hsync_d;
    logic [1:0] vsync_d;
    logic [1:0] active_d;

    // ======================================================================
    // Raster counters
    // ======================================================================

    assign h_last  = (x_cnt == H_TOTAL - 10'd1);
    assign v_last  = (y_cnt == V_TOTAL - 10'd1);
    // One line early, so the renderer can prepare line 0 in the last line
    assign v_last2 = (y_cnt == V_TOTAL - 10'd2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            x_cnt <= h_last ? '0 : x_cnt + 10'd1;
            if (h_last) begin
                y_cnt <= v_last ? '0 : y_cnt + 10'd1;
            end
        end
    end

    assign hsync  = (x_cnt >= H_ACTIVE + H_FRONT_PORCH) &&
                    (x_cnt <  H_ACTIVE + H_FRONT_PORCH + H_SYNC);
    assign vsync  = (y_cnt >= V_ACTIVE + V_FRONT_PORCH) &&
                    (y_cnt <  V_ACTIVE + V_FRONT_PORCH + V_SYNC);
    assign active = (x_cnt < H_ACTIVE) && (y_cnt < V_ACTIVE);

    assign start_of_line   = h_last;
    assign start_of_screen = h_last && v_last2;
    assign linebuf_idx     = x_cnt;

    // ======================================================================
    // Output stage
    // ======================================================================

    // Line buffer read and palette lookup each add one register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_d   <= '0;
            vsync_d   <= '0;
            active_d  <= '0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
        end else begin
            hsync_d  <= {hsync_d[0], hsync};
            vsync_d  <= {vsync_d[0], vsync};
            active_d <= {active_d[0], active};

            // Blank outside the visible area
            vga_r <= active_d[1] ? rgb_data.r : 4'd0;
            vga_g <= active_d[1] ? rgb_data.g : 4'd0;
            vga_b <= active_d[1] ? rgb_data.b : 4'd0;

            vga_hsync <= hsync_d[1];
            vga_vsync <= vsync_d[1];
        end
    end

    // The frame strobe is always also a line strobe, the renderer relies on it
    a_screen_is_line: assert property (
        @(posedge clk) disable iff (rst) start_of_screen |-> start_of_line
    ) else $error("start_of_screen without start_of_line");

endmodule

`default_nettype wire

// File: render_if.sv
`timescale 1ns/10ps
`default_nettype none

// Write path from the line renderer into the back bank of the line buffer
interface render_if (
    input wire clk
);
    import video_pkg::*;

    logic     wr_en;
    coord_t   wr_idx;
    pal_idx_t wr_color;

    modport renderer (
        input  clk,
        output wr_en,
        output wr_idx,
        output wr_color
    );

    modport buffer (
        input clk,
        input wr_en,
        input wr_idx,
        input wr_color
    );

endinterface

`default_nettype wire

// File: video_pkg.sv
`default_nettype none

package video_pkg;

    // ======================================================================
    // Basic types
    // ======================================================================

    // Pixel or line coordinate, wide enough for the full 800x525 raster
    typedef logic [9:0] coord_t;

    // Index into the colour table
    typedef logic [7:0] pal_idx_t;

    // 4:4:4 colour as driven onto the VGA DAC pins
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // ======================================================================
    // 640x480 at 60 Hz timing
    // ======================================================================

    localparam coord_t H_ACTIVE      = 10'd640;
    localparam coord_t H_FRONT_PORCH = 10'd16;
    localparam coord_t H_SYNC        = 10'd96;
    localparam coord_t H_BACK_PORCH  = 10'd48;
    localparam coord_t H_TOTAL       = H_ACTIVE + H_FRONT_PORCH + H_SYNC + H_BACK_PORCH;

    localparam coord_t V_ACTIVE      = 10'd480;
    localparam coord_t V_FRONT_PORCH = 10'd10;
    localparam coord_t V_SYNC        = 10'd2;
    localparam coord_t V_BACK_PORCH  = 10'd33;
    localparam coord_t V_TOTAL       = V_ACTIVE + V_FRONT_PORCH + V_SYNC + V_BACK_PORCH;

    // ======================================================================
    // Renderer FSM
    // ======================================================================

    typedef enum logic {
        RS_IDLE,
        RS_FILL
    } render_state_t;

endpackage

`default_nettype wire
